// File: Makefile
# Verilator build and run of the fetch front end testbench
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= *** TEST FAILED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hdl/fetch_params.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/inst_pkg.sv
hdl/pc_gen.sv
hdl/icache.sv
hdl/fetch.sv
hdl/inst_buffer.sv
hdl/fetch_top.sv
tb/fetch_assert.sv
tb/fetch_tb.sv

// File: hdl/fetch.sv
`include "fetch_params.svh"

module fetch (
    input  logic                                         clock,
    input  logic                                         reset,
    input  inst_pkg::br_task_t                           br_task,
    input  mem_pkg::addr_t                               target,
    input  logic                                         arbiter_signal,
    input  logic [$clog2(`INST_BUFF_DEPTH+1)-1:0]        ibuff_open,
    input  mem_pkg::mem_tag_t                            mem_transaction_tag,
    input  mem_pkg::mem_tag_t                            mem_data_tag,
    input  mem_pkg::mem_block_t                          mem_data,
    output logic                                         mem_en,
    output mem_pkg::addr_t                               mem_addr,
    output logic [$clog2(`FETCH_WIDTH+1)-1:0]            fetch_count,
    output inst_pkg::inst_packet_t [`FETCH_WIDTH-1:0]    out_insts,
    output logic [$clog2(`FETCH_WIDTH+1)-1:0]            out_num_insts
);
    import mem_pkg::*;
    import inst_pkg::*;

    localparam int CNT_BITS = $clog2(`FETCH_WIDTH+1);
    localparam int PD = `PREFETCH_DISTANCE;

    // miss status table, one entry per memory tag
    addr_t                  mshr_addr [1:`NUM_MEM_TAGS];
    logic [`NUM_MEM_TAGS:1] mshr_valid;

    logic                   squash, mshr_full, mem_done, req_accepted;
    addr_t                  base_addr, cache_write_addr;
    mem_block_t [PD-1:0]    cache_data;
    logic [PD-1:0]          cache_hit, cache_pending, need_block;
    logic [CNT_BITS-1:0]    avail_count;
    inst_packet_t [`FETCH_WIDTH-1:0] next_insts;

    assign squash       = br_task == BR_SQUASH;
    assign base_addr    = {target[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
    assign mshr_full    = &mshr_valid;
    // reply for a tag we still track, stale tags drop out here
    assign mem_done     = (mem_data_tag != '0) && mshr_valid[mem_data_tag];
    assign req_accepted = mem_en && (mem_transaction_tag != '0);
    assign cache_write_addr = mshr_addr[mem_data_tag];

    // block already requested and not yet back
    always_comb begin
        addr_t blk;
        for (int i = 0; i < PD; i++) begin
            blk = base_addr + addr_t'(BLOCK_BYTES * i);
            cache_pending[i] = 1'b0;
            for (int j = 1; j <= `NUM_MEM_TAGS; j++) begin
                if (mshr_valid[j] && (mshr_addr[j] == blk)) begin
                    cache_pending[i] = 1'b1;
                end
            end
            need_block[i] = !cache_hit[i] && !cache_pending[i];
        end
    end

    // one request per cycle, nearest block first
    always_comb begin
        mem_en   = 1'b0;
        mem_addr = base_addr;
        for (int i = PD - 1; i >= 0; i--) begin
            if (need_block[i]) begin
                mem_en   = arbiter_signal && !mshr_full && !squash;
                mem_addr = base_addr + addr_t'(BLOCK_BYTES * i);
            end
        end
    end

    // run of consecutive words whose blocks hit
    always_comb begin
        int   off;
        logic run;
        avail_count = '0;
        run         = 1'b1;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            off = int'(target[2]) + i;
            if (run && (off / 2 < PD) && cache_hit[off / 2]) begin
                avail_count = avail_count + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
        // nothing accepted on a redirect
        if (squash) begin
            fetch_count = '0;
        end else if ({1'b0, avail_count} < ibuff_open) begin
            fetch_count = avail_count;
        end else begin
            fetch_count = ibuff_open[CNT_BITS-1:0];
        end
    end

    // packet assembly, word picked by pc bit 2
    always_comb begin
        addr_t pc;
        int    off;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            pc  = target + addr_t'(4 * i);
            off = int'(target[2]) + i;
            next_insts[i] = '0;
            if (i < fetch_count) begin
                next_insts[i].valid      = 1'b1;
                next_insts[i].inst       = cache_data[off / 2][pc[2]];
                next_insts[i].pc         = pc;
                next_insts[i].npc        = pc + 32'd4;
                next_insts[i].pred_taken = 1'b0;
            end
        end
    end

    icache i_icache (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (target),
        .write_en    (mem_done),
        .write_addr  (cache_write_addr),
        .write_data  (mem_data),
        .read_data   (cache_data),
        .read_valid  (cache_hit)
    );

    // entry freed on reply, allocated on accept
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            mshr_valid    <= '0;
            out_num_insts <= '0;
        end else begin
            if (mem_done) begin
                mshr_valid[mem_data_tag] <= 1'b0;
            end
            if (req_accepted) begin
                mshr_valid[mem_transaction_tag] <= 1'b1;
            end
            out_num_insts <= fetch_count;
        end
    end

    always_ff @(posedge clock) begin
        if (req_accepted) begin
            mshr_addr[mem_transaction_tag] <= mem_addr;
        end
        out_insts <= next_insts;
    end

endmodule

// File: hdl/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0000
// memory tags run 1..15, tag 0 means no tag
`define NUM_MEM_TAGS 15
// blocks looked at from the fetch target
`define PREFETCH_DISTANCE 2
`define ICACHE_LINES 16
`define INST_BUFF_DEPTH 8
`define FETCH_WIDTH 4
`define DISPATCH_WIDTH 2

`endif

// File: hdl/fetch_top.sv
`include "fetch_params.svh"

module fetch_top (
    input  logic                                         clock,
    input  logic                                         reset,
    input  inst_pkg::br_task_t                           br_task,
    input  mem_pkg::addr_t                               br_target,
    input  logic                                         arbiter_signal,
    input  mem_pkg::mem_tag_t                            mem_transaction_tag,
    input  mem_pkg::mem_tag_t                            mem_data_tag,
    input  mem_pkg::mem_block_t                          mem_data,
    input  logic                                         dispatch_ready,
    output logic                                         mem_en,
    output mem_pkg::addr_t                               mem_addr,
    output inst_pkg::inst_packet_t [`DISPATCH_WIDTH-1:0] dispatch_insts,
    output logic [$clog2(`DISPATCH_WIDTH+1)-1:0]         dispatch_count
);
    import mem_pkg::*;
    import inst_pkg::*;

    // current fetch address
    addr_t target;
    // accepted this cycle
    logic [$clog2(`FETCH_WIDTH+1)-1:0] fetch_count;
    // fetch output register into the buffer
    inst_packet_t [`FETCH_WIDTH-1:0] out_insts;
    logic [$clog2(`FETCH_WIDTH+1)-1:0] out_num_insts;
    // free buffer slots net of in-flight packets
    logic [$clog2(`INST_BUFF_DEPTH+1)-1:0] ibuff_open;

    pc_gen i_pc_gen (
        .clock       (clock),
        .reset       (reset),
        .br_task     (br_task),
        .br_target   (br_target),
        .fetch_count (fetch_count),
        .target      (target)
    );

    fetch i_fetch (
        .clock               (clock),
        .reset               (reset),
        .br_task             (br_task),
        .target              (target),
        .arbiter_signal      (arbiter_signal),
        .ibuff_open          (ibuff_open),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .fetch_count         (fetch_count),
        .out_insts           (out_insts),
        .out_num_insts       (out_num_insts)
    );

    inst_buffer i_inst_buffer (
        .clock          (clock),
        .reset          (reset),
        .br_task        (br_task),
        .in_insts       (out_insts),
        .in_num_insts   (out_num_insts),
        .dispatch_ready (dispatch_ready),
        .ibuff_open     (ibuff_open),
        .dispatch_insts (dispatch_insts),
        .dispatch_count (dispatch_count)
    );

endmodule

// File: hdl/icache.sv
`include "fetch_params.svh"

module icache (
    input  logic                                          clock,
    input  logic                                          reset,
    input  mem_pkg::addr_t                                lookup_addr,
    input  logic                                          write_en,
    input  mem_pkg::addr_t                                write_addr,
    input  mem_pkg::mem_block_t                           write_data,
    output mem_pkg::mem_block_t [`PREFETCH_DISTANCE-1:0] read_data,
    output logic [`PREFETCH_DISTANCE-1:0]                 read_valid
);
    import mem_pkg::*;

    // index sits right above the block offset
    localparam int IDX_BITS = $clog2(`ICACHE_LINES);
    localparam int TAG_BITS = $bits(addr_t) - BLOCK_OFFSET_BITS - IDX_BITS;

    // line storage
    mem_block_t          data_mem [`ICACHE_LINES];
    logic [TAG_BITS-1:0] tag_mem  [`ICACHE_LINES];
    // cleared only by reset
    logic [`ICACHE_LINES-1:0] line_valid;

    logic [IDX_BITS-1:0] write_idx;
    logic [TAG_BITS-1:0] write_tag;

    assign write_idx = write_addr[BLOCK_OFFSET_BITS +: IDX_BITS];
    assign write_tag = write_addr[$bits(addr_t)-1 -: TAG_BITS];

    // lookup of the target block and the blocks after it
    always_comb begin
        addr_t               blk_addr;
        logic [IDX_BITS-1:0] idx;
        for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
            blk_addr      = lookup_addr + addr_t'(BLOCK_BYTES * i);
            idx           = blk_addr[BLOCK_OFFSET_BITS +: IDX_BITS];
            read_data[i]  = data_mem[idx];
            // hit needs a valid line with a matching tag
            read_valid[i] = line_valid[idx] &&
                            (tag_mem[idx] == blk_addr[$bits(addr_t)-1 -: TAG_BITS]);
        end
    end

    // refill replaces the whole line
    always_ff @(posedge clock) begin
        if (write_en) begin
            data_mem[write_idx] <= write_data;
            tag_mem[write_idx]  <= write_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (write_en) begin
            line_valid[write_idx] <= 1'b1;
        end
    end

endmodule

// File: hdl/inst_buffer.sv
`include "fetch_params.svh"

module inst_buffer (
    input  logic                                         clock,
    input  logic                                         reset,
    input  inst_pkg::br_task_t                           br_task,
    input  inst_pkg::inst_packet_t [`FETCH_WIDTH-1:0]    in_insts,
    input  logic [$clog2(`FETCH_WIDTH+1)-1:0]            in_num_insts,
    input  logic                                         dispatch_ready,
    output logic [$clog2(`INST_BUFF_DEPTH+1)-1:0]        ibuff_open,
    output inst_pkg::inst_packet_t [`DISPATCH_WIDTH-1:0] dispatch_insts,
    output logic [$clog2(`DISPATCH_WIDTH+1)-1:0]         dispatch_count
);
    import inst_pkg::*;

    localparam int PTR_BITS = $clog2(`INST_BUFF_DEPTH);
    localparam int CNT_BITS = $clog2(`INST_BUFF_DEPTH+1);
    localparam int DC_BITS  = $clog2(`DISPATCH_WIDTH+1);

    inst_packet_t entries [`INST_BUFF_DEPTH];
    logic [PTR_BITS-1:0] head, tail;
    logic [CNT_BITS-1:0] count, num_read;

    always_comb begin
        // head entries visible without a read strobe
        if (count < CNT_BITS'(`DISPATCH_WIDTH)) begin
            dispatch_count = count[DC_BITS-1:0];
        end else begin
            dispatch_count = DC_BITS'(`DISPATCH_WIDTH);
        end
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            dispatch_insts[i] = entries[head + PTR_BITS'(i)];
        end
    end

    // taken only while the back end is ready
    assign num_read = dispatch_ready ? CNT_BITS'(dispatch_count) : '0;
    // packets in the fetch register already hold a slot
    assign ibuff_open = CNT_BITS'(`INST_BUFF_DEPTH) - count - CNT_BITS'(in_num_insts);

    always_ff @(posedge clock) begin
        if (reset || (br_task == BR_SQUASH)) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_BITS'(num_read);
            tail  <= tail + PTR_BITS'(in_num_insts);
            count <= count + CNT_BITS'(in_num_insts) - num_read;
        end
    end

    // write at tail, wraps around
    always_ff @(posedge clock) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (i < in_num_insts) begin
                entries[tail + PTR_BITS'(i)] <= in_insts[i];
            end
        end
    end

endmodule

// File: hdl/inst_pkg.sv
package inst_pkg;

    // one fetched instruction and its addresses
    typedef struct packed {
        logic           valid;
        logic [31:0]    inst;
        mem_pkg::addr_t pc;
        mem_pkg::addr_t npc;
        // no predictor yet
        logic           pred_taken;
    } inst_packet_t;

    // redirect request from the back end
    // clear means prediction was right, keep fetching
    // squash means restart from br_target
    typedef enum logic [1:0] {
        BR_NONE,
        BR_CLEAR,
        BR_SQUASH
    } br_task_t;

endpackage

// File: hdl/mem_pkg.sv
package mem_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // memory transaction tag, zero means none
    typedef logic [3:0] mem_tag_t;

    // 8-byte block as two words
    // word 1 sits at byte offset 4
    typedef logic [1:0][31:0] mem_block_t;

    // bytes per block
    localparam int BLOCK_BYTES = 8;

    // low address bits inside a block
    localparam int BLOCK_OFFSET_BITS = 3;

endpackage

// File: hdl/pc_gen.sv
`include "fetch_params.svh"

module pc_gen (
    input  logic                              clock,
    input  logic                              reset,
    input  inst_pkg::br_task_t                br_task,
    input  mem_pkg::addr_t                    br_target,
    input  logic [$clog2(`FETCH_WIDTH+1)-1:0] fetch_count,
    output mem_pkg::addr_t                    target
);
    import mem_pkg::*;
    import inst_pkg::*;

    // bytes consumed by this cycle's fetch
    addr_t advance;

    // four bytes per accepted instruction
    assign advance = addr_t'({fetch_count, 2'b00});

    always_ff @(posedge clock) begin
        if (reset) begin
            target <= `RESET_PC;
        end else if (br_task == BR_SQUASH) begin
            // redirect wins over sequential advance
            target <= br_target;
        end else begin
            // zero count holds the address
            target <= target + advance;
        end
    end

endmodule

// File: tb/fetch_assert.sv
`include "fetch_params.svh"

module fetch_assert (
    input logic                                 clock,
    input logic                                 reset,
    input logic                                 arbiter_signal,
    input logic                                 mem_en,
    input mem_pkg::addr_t                       mem_addr,
    input logic [$clog2(`DISPATCH_WIDTH+1)-1:0] dispatch_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    // failed assertion count
    int error_count = 0;

    // reads are whole blocks
    mem_addr_aligned: assert property (@(posedge clock) disable iff (reset)
        mem_en |-> mem_addr[BLOCK_OFFSET_BITS-1:0] == '0)
        else begin
            error_count++;
            $error("mem_addr %h is not block aligned", mem_addr);
        end

    // no request without the bus grant
    mem_en_granted: assert property (@(posedge clock) disable iff (reset)
        mem_en |-> arbiter_signal)
        else begin
            error_count++;
            $error("mem_en high while arbiter_signal is low");
        end

    dispatch_bounded: assert property (@(posedge clock) disable iff (reset)
        dispatch_count <= `DISPATCH_WIDTH)
        else begin
            error_count++;
            $error("dispatch_count %0d above dispatch width", dispatch_count);
        end

endmodule

// File: tb/fetch_tb.sv
`include "fetch_params.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;
    import inst_pkg::*;

    localparam int CLOCK_PERIOD    = 10;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    // DUT inputs start at known values
    logic       clock               = 1'b0;
    logic       reset               = 1'b1;
    br_task_t   br_task             = BR_NONE;
    addr_t      br_target           = '0;
    logic       arbiter_signal      = 1'b0;
    mem_tag_t   mem_transaction_tag = '0;
    mem_tag_t   mem_data_tag        = '0;
    mem_block_t mem_data            = '0;
    logic       dispatch_ready      = 1'b0;

    logic                                 mem_en;
    addr_t                                mem_addr;
    inst_packet_t [`DISPATCH_WIDTH-1:0]   dispatch_insts;
    logic [$clog2(`DISPATCH_WIDTH+1)-1:0] dispatch_count;

    // memory model state, one slot per tag
    addr_t                  req_addr  [1:`NUM_MEM_TAGS];
    int                     req_delay [1:`NUM_MEM_TAGS];
    int                     req_seq   [1:`NUM_MEM_TAGS];
    logic [`NUM_MEM_TAGS:1] req_busy;
    // issued before the last squash
    logic [`NUM_MEM_TAGS:1] req_stale;
    mem_tag_t               next_tag;
    int                     seq_count;
    int                     seed      = 32'h0518_72bb;
    logic                   reorder   = 1'b0;
    int                     ooo_seen  = 0;

    // which block each cache line holds
    addr_t                    line_addr [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] line_valid;

    // program order reference
    addr_t expect_pc  = `RESET_PC;
    logic  watch_on   = 1'b0;
    addr_t watch_addr = '0;

    fetch_top i_fetch_top (
        .clock               (clock),
        .reset               (reset),
        .br_task             (br_task),
        .br_target           (br_target),
        .arbiter_signal      (arbiter_signal),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .dispatch_ready      (dispatch_ready),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .dispatch_insts      (dispatch_insts),
        .dispatch_count      (dispatch_count)
    );

    bind fetch_top fetch_assert i_fetch_assert (
        .clock          (clock),
        .reset          (reset),
        .arbiter_signal (arbiter_signal),
        .mem_en         (mem_en),
        .mem_addr       (mem_addr),
        .dispatch_count (dispatch_count)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping after the first failure");
    endtask

    // cache index is address bits 6:3
    function automatic int line_of(input addr_t a);
        return int'(a[BLOCK_OFFSET_BITS +: $clog2(`ICACHE_LINES)]);
    endfunction

    task automatic check_packet(input inst_packet_t pkt);
        assert (pkt.valid && pkt.pc == expect_pc && pkt.inst == ~pkt.pc &&
                pkt.npc == pkt.pc + 32'd4 && !pkt.pred_taken)
        else begin
            $display("CHECK FAILED at %0t: pc %h inst %h npc %h valid %b pred %b, expected pc %h",
                     $time, pkt.pc, pkt.inst, pkt.npc, pkt.valid, pkt.pred_taken, expect_pc);
            abort_run();
        end
        expect_pc = expect_pc + 32'd4;
    endtask

    task automatic check_idle(input string when);
        assert (dispatch_count == '0 && !mem_en)
        else begin
            $display("CHECK FAILED at %0t: dispatch_count %0d mem_en %b %s",
                     $time, dispatch_count, mem_en, when);
            abort_run();
        end
    endtask

    task automatic wait_pc(input addr_t limit);
        do begin
            @(negedge clock);
        end while (expect_pc < limit);
        @(posedge clock);
    endtask

    task automatic squash_to(input addr_t addr);
        @(posedge clock);
        br_task   <= BR_SQUASH;
        br_target <= addr;
        @(posedge clock);
        br_task <= BR_NONE;
    endtask

    task automatic reset_test();
        // registers take reset at the first edge
        @(posedge clock);
        repeat (2) begin
            @(posedge clock);
            check_idle("during reset");
        end
        reset <= 1'b0;
        repeat (2) begin
            @(posedge clock);
            check_idle("after reset");
        end
        arbiter_signal <= 1'b1;
        dispatch_ready <= 1'b1;
        do begin
            @(posedge clock);
        end while (!mem_en);
        assert (mem_addr == `RESET_PC)
        else begin
            $display("CHECK FAILED at %0t: first request %h, expected %h",
                     $time, mem_addr, `RESET_PC);
            abort_run();
        end
    endtask

    task automatic straight_test();
        wait_pc(32'h20);
        // correct prediction, no redirect
        @(posedge clock);
        br_task <= BR_CLEAR;
        @(posedge clock);
        br_task <= BR_NONE;
        wait_pc(32'h40);
    endtask

    task automatic backpressure_test();
        dispatch_ready <= 1'b0;
        repeat (40) @(posedge clock);
        assert (dispatch_count == `DISPATCH_WIDTH)
        else begin
            $display("CHECK FAILED at %0t: buffer head holds %0d packets after stall",
                     $time, dispatch_count);
            abort_run();
        end
        arbiter_signal <= 1'b0;
        dispatch_ready <= 1'b1;
        repeat (20) begin
            @(posedge clock);
            assert (!mem_en)
            else begin
                $display("CHECK FAILED at %0t: request %h with arbiter low", $time, mem_addr);
                abort_run();
            end
        end
        arbiter_signal <= 1'b1;
        wait_pc(32'h60);
    endtask

    task automatic squash_test();
        squash_to(32'h100);
        wait_pc(32'h120);
    endtask

    task automatic reorder_test();
        int seen_before;
        reorder <= 1'b1;
        squash_to(32'h200);
        // count only overtakes among requests made after the squash
        @(negedge clock);
        seen_before = ooo_seen;
        wait_pc(32'h220);
        reorder <= 1'b0;
        @(negedge clock);
        assert (ooo_seen > seen_before)
        else begin
            $display("CHECK FAILED at %0t: no reply overtook an older request", $time);
            abort_run();
        end
    endtask

    task automatic hit_test(input addr_t blk);
        logic held;
        @(negedge clock);
        held = line_valid[line_of(blk)] && line_addr[line_of(blk)] == blk;
        assert (held)
        else begin
            $display("cache model does not hold block %h, hit test cannot run", blk);
            abort_run();
        end
        @(posedge clock);
        watch_addr <= blk;
        watch_on   <= 1'b1;
        squash_to(blk);
        wait_pc(blk + 32'd8);
        watch_on <= 1'b0;
    endtask

    // memory model with random accept, 2 to 9 cycles of latency and ~a as the word at a
    always @(posedge clock) begin
        int       pick;
        mem_tag_t tag;
        if (reset) begin
            req_busy            = '0;
            req_stale           = '0;
            line_valid          = '0;
            next_tag            = mem_tag_t'(1);
            seq_count           = 0;
            mem_transaction_tag <= '0;
            mem_data_tag        <= '0;
        end else begin
            // reply seen last cycle fills its line unless the tag was squashed
            if (mem_data_tag != '0 && !req_stale[mem_data_tag]) begin
                line_addr[line_of(req_addr[mem_data_tag])]  = req_addr[mem_data_tag];
                line_valid[line_of(req_addr[mem_data_tag])] = 1'b1;
            end
            // the DUT forgets tags in flight at a squash
            if (br_task == BR_SQUASH) begin
                req_stale = req_stale | req_busy;
            end
            if (mem_en && mem_transaction_tag != '0) begin
                tag            = mem_transaction_tag;
                req_busy[tag]  = 1'b1;
                req_stale[tag] = 1'b0;
                req_addr[tag]  = mem_addr;
                req_seq[tag]   = seq_count;
                seq_count      = seq_count + 1;
                // even blocks slow, odd blocks fast
                if (reorder) begin
                    req_delay[tag] = mem_addr[3] ? 2 : 9;
                end else begin
                    req_delay[tag] = 2 + ($random(seed) & 7);
                end
                if (next_tag == mem_tag_t'(`NUM_MEM_TAGS)) begin
                    next_tag = mem_tag_t'(1);
                end else begin
                    next_tag = next_tag + mem_tag_t'(1);
                end
            end
            // one reply per cycle from the lowest ready tag
            pick = 0;
            for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
                if (req_busy[i]) begin
                    req_delay[i] = req_delay[i] - 1;
                    if (req_delay[i] <= 0) begin
                        pick = i;
                    end
                end
            end
            mem_data_tag <= '0;
            if (pick != 0) begin
                for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
                    // squashed requests take no part in the ordering
                    if (req_busy[i] && !req_stale[i] && !req_stale[pick] &&
                        req_seq[i] < req_seq[pick]) begin
                        ooo_seen = ooo_seen + 1;
                    end
                end
                req_busy[pick] = 1'b0;
                mem_data_tag   <= mem_tag_t'(pick);
                mem_data       <= {~(req_addr[pick] + 32'd4), ~req_addr[pick]};
            end
            // offer a free tag when the random bit allows
            mem_transaction_tag <= '0;
            if (!req_busy[next_tag] && (($random(seed) & 1) != 0)) begin
                mem_transaction_tag <= next_tag;
            end
        end
    end

    // dispatch checker against program order
    always @(posedge clock) begin
        if (i_fetch_top.i_fetch_assert.error_count != 0) begin
            $display("a concurrent assertion in fetch_assert failed at %0t", $time);
            abort_run();
        end
        if (reset) begin
            expect_pc = `RESET_PC;
        end else if (br_task == BR_SQUASH) begin
            // squash drops whatever sits at the head
            expect_pc = br_target;
        end else begin
            assert (!(watch_on && mem_en && mem_addr == watch_addr))
            else begin
                $display("CHECK FAILED at %0t: request for cached block %h", $time, mem_addr);
                abort_run();
            end
            if (dispatch_ready) begin
                for (int i = 0; i < int'(dispatch_count); i++) begin
                    check_packet(dispatch_insts[i]);
                end
            end
        end
    end

    // watchdog sized from the test count
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLOCK_PERIOD);
        $display("watchdog expired, the DUT stopped making progress at pc %h", expect_pc);
        abort_run();
    end

    initial begin
        reset_test();
        straight_test();
        backpressure_test();
        squash_test();
        reorder_test();
        hit_test(32'h40);
        @(negedge clock);
        if (i_fetch_top.i_fetch_assert.error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule
